/* rtl/datamem_pkg.sv */
// Data memory word, address and line types, line geometry, arbiter grant encoding
package datamem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Line geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 16;

    // Low address bits that pick a word inside a line
    localparam int WORD_SEL_BITS  = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    // Word address, one location per 32-bit word
    typedef logic [15:0] addr_t;

    typedef logic [WORD_BITS-1:0] word_t;

    // Sixteen words, word 0 in the low bits
    typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

    // Address bits above the word select, 12 bits
    typedef logic [$bits(addr_t)-WORD_SEL_BITS-1:0] line_index_t;

    // Which requester the memory served in a cycle
    typedef enum logic [1:0] {
        SERVED_NONE,
        SERVED_HOST,
        SERVED_CPU,
        SERVED_ACCEL
    } served_port_t;

endpackage

/* rtl/accel_req_queue.sv */
// In-order request queue for the accelerator port, one slot per credit
`timescale 1ns/1ns

module accel_req_queue #(
    parameter int ACCEL_CREDITS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  logic               push_wrt,
    input  datamem_pkg::addr_t push_addr,
    input  datamem_pkg::word_t push_wrt_data,
    input  logic               head_pop,
    output logic               head_valid,
    output logic               head_wrt,
    output datamem_pkg::addr_t head_addr,
    output datamem_pkg::word_t head_wrt_data
);

    import datamem_pkg::*;

    localparam int PTR_BITS = (ACCEL_CREDITS > 1) ? $clog2(ACCEL_CREDITS) : 1;
    localparam int CNT_BITS = $clog2(ACCEL_CREDITS + 1);

    // Request slots
    logic  slot_wrt  [ACCEL_CREDITS];
    addr_t slot_addr [ACCEL_CREDITS];
    word_t slot_data [ACCEL_CREDITS];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(ACCEL_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (head_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, head_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Overflow is ruled out by the credit count
    always_ff @(posedge clk) begin
        if (push) begin
            slot_wrt[wr_ptr]  <= push_wrt;
            slot_addr[wr_ptr] <= push_addr;
            slot_data[wr_ptr] <= push_wrt_data;
        end
    end

    // Head is visible the cycle after the push
    assign head_valid    = (count != '0);
    assign head_wrt      = slot_wrt[rd_ptr];
    assign head_addr     = slot_addr[rd_ptr];
    assign head_wrt_data = slot_data[rd_ptr];

endmodule

/* rtl/datamem_arbiter.sv */
// Fixed-priority request selection for host, CPU and accelerator queue head
`timescale 1ns/1ns

module datamem_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ex_rd_en,
    input  logic                      ex_wrt_en,
    input  datamem_pkg::addr_t        ex_addr,
    input  datamem_pkg::word_t        ex_wrt_data,
    input  logic                      cpu_rd_en,
    input  logic                      cpu_wrt_en,
    input  datamem_pkg::addr_t        cpu_addr,
    input  datamem_pkg::word_t        cpu_wrt_data,
    input  logic                      head_valid,
    input  logic                      head_wrt,
    input  datamem_pkg::addr_t        head_addr,
    input  datamem_pkg::word_t        head_wrt_data,
    output logic                      head_pop,
    output datamem_pkg::addr_t        mem_addr,
    output logic                      mem_rd_en,
    output logic                      mem_wrt_en,
    output datamem_pkg::word_t        mem_wrt_data,
    output datamem_pkg::served_port_t served_port,
    output logic                      served_wrt,
    output logic [datamem_pkg::WORD_SEL_BITS-1:0] served_offset
);

    import datamem_pkg::*;

    logic         ex_req;
    logic         cpu_req;
    served_port_t grant;
    logic         grant_wrt;

    assign ex_req  = ex_rd_en | ex_wrt_en;
    assign cpu_req = cpu_rd_en | cpu_wrt_en;

    ////////////////////////////////////////////////////////////////////////////
    // Request decode, host first, then CPU, then queue head
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_addr     = head_addr;
        mem_wrt_data = head_wrt_data;
        mem_wrt_en   = 1'b0;
        mem_rd_en    = 1'b0;
        grant        = SERVED_NONE;
        grant_wrt    = 1'b0;
        if (ex_req) begin
            mem_addr     = ex_addr;
            mem_wrt_data = ex_wrt_data;
            mem_wrt_en   = ex_wrt_en;
            mem_rd_en    = ex_rd_en & ~ex_wrt_en;
            grant        = SERVED_HOST;
            grant_wrt    = ex_wrt_en;
        end else if (cpu_req) begin
            mem_addr     = cpu_addr;
            mem_wrt_data = cpu_wrt_data;
            mem_wrt_en   = cpu_wrt_en;
            mem_rd_en    = cpu_rd_en & ~cpu_wrt_en;
            grant        = SERVED_CPU;
            grant_wrt    = cpu_wrt_en;
        end else if (head_valid) begin
            mem_wrt_en   = head_wrt;
            mem_rd_en    = ~head_wrt;
            grant        = SERVED_ACCEL;
            grant_wrt    = head_wrt;
        end
    end

    // Head leaves the queue only on an idle host and CPU cycle
    assign head_pop = head_valid & ~ex_req & ~cpu_req;

    // Grant record for the result stage, one cycle behind the memory access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            served_port   <= SERVED_NONE;
            served_wrt    <= 1'b0;
            served_offset <= '0;
        end else begin
            served_port   <= grant;
            served_wrt    <= grant_wrt;
            served_offset <= mem_addr[WORD_SEL_BITS-1:0];
        end
    end

endmodule

/* rtl/datamem_array.sv */
// Word-write, line-read data storage with registered line output
`timescale 1ns/1ns

module datamem_array #(
    parameter int MEM_LINES = 64
) (
    input  logic               clk,
    input  datamem_pkg::addr_t mem_addr,
    input  logic               mem_rd_en,
    input  logic               mem_wrt_en,
    input  datamem_pkg::word_t mem_wrt_data,
    output datamem_pkg::line_t rd_line
);

    import datamem_pkg::*;

    // Power-of-two line count, higher index bits wrap
    localparam int LINE_BITS = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

    line_t mem [MEM_LINES];

    line_index_t              line_idx;
    logic [LINE_BITS-1:0]     row;
    logic [WORD_SEL_BITS-1:0] word_off;

    ////////////////////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////////////////////

    assign line_idx = mem_addr[$bits(addr_t)-1:WORD_SEL_BITS];
    assign row      = line_idx[LINE_BITS-1:0];
    assign word_off = mem_addr[WORD_SEL_BITS-1:0];

    // One word lands inside its line
    always_ff @(posedge clk) begin
        if (mem_wrt_en) begin
            mem[row][word_off*WORD_BITS +: WORD_BITS] <= mem_wrt_data;
        end
    end

    // Whole line out, held until the next read
    always_ff @(posedge clk) begin
        if (mem_rd_en) begin
            rd_line <= mem[row];
        end
    end

endmodule

/* rtl/datamem_result.sv */
// Read word selection, accelerator line delivery, completion and credit pulses
`timescale 1ns/1ns

module datamem_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  datamem_pkg::served_port_t served_port,
    input  logic                      served_wrt,
    input  logic [datamem_pkg::WORD_SEL_BITS-1:0] served_offset,
    input  datamem_pkg::line_t        rd_line,
    output datamem_pkg::word_t        cpu_rd_data,
    output datamem_pkg::word_t        ex_rd_data,
    output datamem_pkg::line_t        accel_rd_data,
    output logic                      accel_rd_valid,
    output logic                      accel_wrt_done,
    output logic                      accel_credit
);

    import datamem_pkg::*;

    word_t rd_word;
    word_t sel_word;
    logic  word_rd;
    logic  accel_op;

    // Host and CPU reads share one word register
    assign word_rd  = ((served_port == SERVED_HOST) || (served_port == SERVED_CPU)) &&
                      !served_wrt;
    assign accel_op = (served_port == SERVED_ACCEL);
    assign sel_word = rd_line[served_offset*WORD_BITS +: WORD_BITS];

    ////////////////////////////////////////////////////////////////////////////
    // Word hold and accelerator pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_word        <= '0;
            accel_rd_valid <= 1'b0;
            accel_wrt_done <= 1'b0;
            accel_credit   <= 1'b0;
        end else begin
            if (word_rd) begin
                rd_word <= sel_word;
            end
            accel_rd_valid <= accel_op & ~served_wrt;
            accel_wrt_done <= accel_op & served_wrt;
            // Each finished request hands its slot back
            accel_credit   <= accel_op;
        end
    end

    // Line captured so it stays with the valid pulse
    always_ff @(posedge clk) begin
        if (accel_op && !served_wrt) begin
            accel_rd_data <= rd_line;
        end
    end

    assign cpu_rd_data = rd_word;
    assign ex_rd_data  = rd_word;

endmodule

/* rtl/cpu_datamem.sv */
// Shared CPU data memory with host, CPU and credit-controlled accelerator ports
`timescale 1ns/1ns

module cpu_datamem #(
    parameter int MEM_LINES     = 64,
    parameter int ACCEL_CREDITS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ex_rd_en,
    input  logic               ex_wrt_en,
    input  datamem_pkg::addr_t ex_addr,
    input  datamem_pkg::word_t ex_wrt_data,
    output datamem_pkg::word_t ex_rd_data,
    input  logic               cpu_rd_en,
    input  logic               cpu_wrt_en,
    input  datamem_pkg::addr_t cpu_addr,
    input  datamem_pkg::word_t cpu_wrt_data,
    output datamem_pkg::word_t cpu_rd_data,
    input  logic               accel_req_valid,
    input  logic               accel_wrt,
    input  datamem_pkg::addr_t accel_addr,
    input  datamem_pkg::word_t accel_wrt_data,
    output logic               accel_credit,
    output logic               accel_wrt_done,
    output logic               accel_rd_valid,
    output datamem_pkg::line_t accel_rd_data
);

    import datamem_pkg::*;

    // Queue head
    logic  head_valid;
    logic  head_wrt;
    addr_t head_addr;
    word_t head_wrt_data;
    logic  head_pop;

    // Memory access
    addr_t mem_addr;
    logic  mem_rd_en;
    logic  mem_wrt_en;
    word_t mem_wrt_data;
    line_t rd_line;

    // Grant record
    served_port_t             served_port;
    logic                     served_wrt;
    logic [WORD_SEL_BITS-1:0] served_offset;

    accel_req_queue #(
        .ACCEL_CREDITS (ACCEL_CREDITS)
    ) u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (accel_req_valid),
        .push_wrt      (accel_wrt),
        .push_addr     (accel_addr),
        .push_wrt_data (accel_wrt_data),
        .head_pop      (head_pop),
        .head_valid    (head_valid),
        .head_wrt      (head_wrt),
        .head_addr     (head_addr),
        .head_wrt_data (head_wrt_data)
    );

    datamem_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_rd_en      (ex_rd_en),
        .ex_wrt_en     (ex_wrt_en),
        .ex_addr       (ex_addr),
        .ex_wrt_data   (ex_wrt_data),
        .cpu_rd_en     (cpu_rd_en),
        .cpu_wrt_en    (cpu_wrt_en),
        .cpu_addr      (cpu_addr),
        .cpu_wrt_data  (cpu_wrt_data),
        .head_valid    (head_valid),
        .head_wrt      (head_wrt),
        .head_addr     (head_addr),
        .head_wrt_data (head_wrt_data),
        .head_pop      (head_pop),
        .mem_addr      (mem_addr),
        .mem_rd_en     (mem_rd_en),
        .mem_wrt_en    (mem_wrt_en),
        .mem_wrt_data  (mem_wrt_data),
        .served_port   (served_port),
        .served_wrt    (served_wrt),
        .served_offset (served_offset)
    );

    datamem_array #(
        .MEM_LINES (MEM_LINES)
    ) u_array (
        .clk          (clk),
        .mem_addr     (mem_addr),
        .mem_rd_en    (mem_rd_en),
        .mem_wrt_en   (mem_wrt_en),
        .mem_wrt_data (mem_wrt_data),
        .rd_line      (rd_line)
    );

    datamem_result u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .served_port    (served_port),
        .served_wrt     (served_wrt),
        .served_offset  (served_offset),
        .rd_line        (rd_line),
        .cpu_rd_data    (cpu_rd_data),
        .ex_rd_data     (ex_rd_data),
        .accel_rd_data  (accel_rd_data),
        .accel_rd_valid (accel_rd_valid),
        .accel_wrt_done (accel_wrt_done),
        .accel_credit   (accel_credit)
    );

endmodule

/* test/datamem_sva.sv */
// Checker on port exclusivity, completion pulses and accelerator credit bounds
`timescale 1ns/1ns

module datamem_sva #(
    parameter int ACCEL_CREDITS = 4
) (
    input logic clk,
    input logic rst_n,
    input logic ex_rd_en,
    input logic ex_wrt_en,
    input logic cpu_rd_en,
    input logic cpu_wrt_en,
    input logic accel_req_valid,
    input logic accel_credit,
    input logic accel_wrt_done,
    input logic accel_rd_valid
);

    // Credits the accelerator still holds
    int avail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avail <= ACCEL_CREDITS;
        end else begin
            avail <= avail - int'(accel_req_valid) + int'(accel_credit);
        end
    end

    host_cpu_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !((ex_rd_en || ex_wrt_en) && (cpu_rd_en || cpu_wrt_en)))
        else $error("host and CPU requested in the same cycle");

    done_valid_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(accel_wrt_done && accel_rd_valid))
        else $error("write done and read valid high together");

    pulse_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
        (accel_wrt_done || accel_rd_valid) |-> accel_credit)
        else $error("completion pulse without credit return");

    credit_bounds: assert property (@(posedge clk) disable iff (!rst_n)
        avail >= 0 && avail <= ACCEL_CREDITS)
        else $error("accelerator credit count out of range");

endmodule

bind cpu_datamem datamem_sva #(.ACCEL_CREDITS(ACCEL_CREDITS)) u_sva (.*);

/* test/datamem_tb.sv */
// Testbench for the shared data memory, driven from the case file, with a shadow memory
`timescale 1ns/1ns

module datamem_tb;

    import datamem_pkg::*;

    localparam int ACCEL_CREDITS = 4;
    localparam int MEM_WORDS     = 64 * WORDS_PER_LINE;
    localparam int TIMEOUT       = 100;

    logic  clk;
    logic  rst_n;
    logic  ex_rd_en;
    logic  ex_wrt_en;
    addr_t ex_addr;
    word_t ex_wrt_data;
    word_t ex_rd_data;
    logic  cpu_rd_en;
    logic  cpu_wrt_en;
    addr_t cpu_addr;
    word_t cpu_wrt_data;
    word_t cpu_rd_data;
    logic  accel_req_valid;
    logic  accel_wrt;
    addr_t accel_addr;
    word_t accel_wrt_data;
    logic  accel_credit;
    logic  accel_wrt_done;
    logic  accel_rd_valid;
    line_t accel_rd_data;

    word_t shadow [MEM_WORDS];
    int    credits;
    int    errors;
    int    tests;
    int    failed;
    int    completions;
    int    seed;
    logic  busy;
    addr_t busy_addr;

    // Outstanding accelerator requests in issue order
    string exp_name [$];
    logic  exp_wrt  [$];
    addr_t exp_addr [$];
    word_t exp_word [$];

    cpu_datamem DUT (.*);

    always #4 clk = ~clk;

    function automatic int widx(input addr_t a);
        return int'(a) % MEM_WORDS;
    endfunction

    function automatic bit word_ok(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("[ERROR] %0s: expected %h, actual %h", name, exp, act);
            errors++;
        end
        return act === exp;
    endfunction

    task automatic report(input string name, input bit bad);
        tests++;
        if (bad) begin
            failed++;
        end
        $display("%0s: %0s", name, bad ? "failed" : "ok");
    endtask

    // Completion check sampled 1 ns after the edge
    task automatic poll_completion();
        string name;
        logic  wrt;
        addr_t a;
        word_t w;
        int    base;
        bit    bad;
        if (accel_credit) begin
            credits++;
        end
        if (accel_wrt_done || accel_rd_valid) begin
            completions++;
            if (exp_name.size() == 0) begin
                $display("Accelerator completion seen with no request outstanding");
                errors++;
            end else begin
                name = exp_name.pop_front();
                wrt  = exp_wrt.pop_front();
                a    = exp_addr.pop_front();
                w    = exp_word.pop_front();
                bad  = 0;
                assert (accel_wrt_done === wrt) else begin
                    $display("[ERROR] %0s: expected write done %0d, actual %0d",
                             name, wrt, accel_wrt_done);
                    errors++;
                    bad = 1;
                end
                if (wrt) begin
                    shadow[widx(a)] = w;
                end else begin
                    base = widx(a) & ~(WORDS_PER_LINE - 1);
                    for (int i = 0; i < WORDS_PER_LINE; i++) begin
                        bad |= !word_ok(name, shadow[base + i], accel_rd_data[i*32 +: 32]);
                    end
                    bad |= !word_ok(name, w, accel_rd_data[a[3:0]*32 +: 32]);
                end
                report(name, bad);
            end
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        poll_completion();
    endtask

    task automatic release_ports();
        ex_rd_en        = 0;
        ex_wrt_en       = 0;
        cpu_wrt_en      = 0;
        cpu_rd_en       = busy;
        cpu_addr        = busy_addr;
        accel_req_valid = 0;
    endtask

    // Wait until every accelerator request completed and all credits are back
    task automatic wait_accel_idle(input string what, output bit bad);
        int waited;
        waited = 0;
        bad = 0;
        while ((exp_name.size() != 0 || credits != ACCEL_CREDITS) && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (exp_name.size() != 0) begin
            $display("Timeout: accelerator requests still outstanding at %0s", what);
            errors++;
            bad = 1;
        end
    endtask

    // Host or CPU word write or read
    task automatic word_access(input string name, input string port,
                               input string op, input addr_t a, input word_t d);
        bit bad;
        bad = 0;
        if (port == "host") begin
            ex_addr = a;
            ex_wrt_data = d;
            ex_wrt_en = (op == "wr");
            ex_rd_en = (op == "rd");
        end else begin
            cpu_addr = a;
            cpu_wrt_data = d;
            cpu_wrt_en = (op == "wr");
            cpu_rd_en = (op == "rd");
        end
        step();
        release_ports();
        if (op == "wr") begin
            shadow[widx(a)] = d;
        end else begin
            // Word shows one edge after the read is sampled
            step();
            bad |= !word_ok(name, shadow[widx(a)], d);
            bad |= !word_ok(name, d, cpu_rd_data);
            bad |= !word_ok(name, d, ex_rd_data);
        end
        report(name, bad);
    endtask

    task automatic accel_issue(input string name, input string op,
                               input addr_t a, input word_t d);
        int gap;
        int waited;
        gap = {$random(seed)} % 3;
        waited = 0;
        repeat (gap) step();
        while (credits == 0 && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (credits == 0) begin
            $display("Timeout: no accelerator credit came back before %0s", name);
            errors++;
            report(name, 1);
        end else begin
            accel_req_valid = 1;
            accel_wrt = (op == "wr");
            accel_addr = a;
            accel_wrt_data = d;
            credits--;
            exp_name.push_back(name);
            exp_wrt.push_back(op == "wr");
            exp_addr.push_back(a);
            exp_word.push_back(d);
            step();
            release_ports();
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    busy_start;
        string line;
        string name;
        string port;
        string op;
        addr_t a;
        word_t d;
        bit    bad;
        clk = 0;
        rst_n = 0;
        seed = 43;
        busy = 0;
        busy_addr = '0;
        busy_start = 0;
        credits = ACCEL_CREDITS;
        errors = 0;
        tests = 0;
        failed = 0;
        completions = 0;
        ex_addr = '0;
        ex_wrt_data = '0;
        cpu_wrt_data = '0;
        accel_wrt = 0;
        accel_addr = '0;
        accel_wrt_data = '0;
        release_ports();
        bad = 0;

        ////////////////////////////////////////////////////////////////////////////
        // Reset state
        ////////////////////////////////////////////////////////////////////////////
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            if (i == 1) begin
                rst_n = 1;
            end
            assert (!accel_credit && !accel_wrt_done && !accel_rd_valid) else begin
                $display("Accelerator pulse seen during or right after reset");
                errors++;
                bad = 1;
            end
            bad |= !word_ok("reset", '0, cpu_rd_data);
        end
        report("reset", bad);

        fd = $fopen("test/datamem_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/datamem_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %s %s %h %h", name, port, op, a, d);
                if (n == 5 && name != "#") begin
                    if (port == "accel") begin
                        accel_issue(name, op, a, d);
                    end else if (op == "busy") begin
                        // Queue starts empty so the hold can use up every credit
                        wait_accel_idle(name, bad);
                        // CPU reads every cycle hold the queue
                        busy = 1;
                        busy_addr = a;
                        busy_start = completions;
                        release_ports();
                        report(name, bad);
                    end else if (op == "idle") begin
                        bad = 0;
                        assert (completions == busy_start) else begin
                            $display("[ERROR] %0s: expected %0d completions, actual %0d",
                                     name, busy_start, completions);
                            errors++;
                            bad = 1;
                        end
                        busy = 0;
                        release_ports();
                        report(name, bad);
                    end else begin
                        word_access(name, port, op, a, d);
                    end
                end
            end
            $fclose(fd);
        end

        // Drain the queue and collect every credit
        wait_accel_idle("credit_return", bad);
        assert (credits == ACCEL_CREDITS) else begin
            $display("[ERROR] credit_return: expected %0d, actual %0d", ACCEL_CREDITS, credits);
            errors++;
            bad = 1;
        end
        report("credit_return", bad);

        $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* test/datamem_cases.txt */
# name port op addr(hex) data-or-expected(hex)
# ops: wr, rd; cpu busy/idle hold CPU reads every cycle at addr
cpu_wr_a    cpu   wr 0010 11110000
host_wr_b   host  wr 0011 22221111
cpu_wr_c    cpu   wr 0012 33332222
cpu_rd_a    cpu   rd 0010 11110000
host_rd_b   host  rd 0011 22221111
host_wr_b2  host  wr 0011 44443333
cpu_rd_b2   cpu   rd 0011 44443333
host_rd_c   host  rd 0012 33332222
line_w0     cpu   wr 0040 a0000000
line_w1     host  wr 0041 a0000001
line_w2     cpu   wr 0042 a0000002
line_w3     host  wr 0043 a0000003
line_w4     cpu   wr 0044 a0000004
line_w5     host  wr 0045 a0000005
line_w6     cpu   wr 0046 a0000006
line_w7     host  wr 0047 a0000007
line_w8     cpu   wr 0048 a0000008
line_w9     host  wr 0049 a0000009
line_w10    cpu   wr 004a a000000a
line_w11    host  wr 004b a000000b
line_w12    cpu   wr 004c a000000c
line_w13    host  wr 004d a000000d
line_w14    cpu   wr 004e a000000e
line_w15    host  wr 004f a000000f
line_rd     accel rd 0045 a0000005
hold_start  cpu   busy 0010 0
acc_wr_0    accel wr 0080 aaaa0001
acc_wr_1    accel wr 0081 aaaa0002
acc_rd_0    accel rd 0080 aaaa0001
acc_wr_2    accel wr 0082 aaaa0003
hold_stop   cpu   idle 0010 0
acc_rd_1    accel rd 0081 aaaa0002
acc_rd_2    accel rd 0082 aaaa0003
cpu_rd_tail cpu   rd 0012 33332222

/* sources.f */
rtl/datamem_pkg.sv
rtl/accel_req_queue.sv
rtl/datamem_arbiter.sv
rtl/datamem_array.sv
rtl/datamem_result.sv
rtl/cpu_datamem.sv
test/datamem_sva.sv
test/datamem_tb.sv

/* Makefile */
# Verilator simulation of the shared data memory

VERILATOR ?= verilator
TOP       ?= datamem_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
